/* src/fetch_pkg.sv */
package fetch_pkg;

    // first fetch address out of reset
    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // major opcodes, inst[31:26]
    localparam logic [5:0] op_b  = 6'b010100;
    localparam logic [5:0] op_bl = 6'b010101;

    // fetch -> decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        // misaligned fetch address
        logic        adef;
    } fetch_payload_t;

    // decode -> retire
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        adef;
        // B or BL, never set together with adef
        logic        is_branch;
    } decode_payload_t;

    // branch redirect, decode -> fetch
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

endpackage

/* src/stage_if.sv */
`timescale 1ns/10ps

// valid/allowin link between two pipeline stages
// a transfer happens when valid and allowin are both high
interface stage_if #(
    parameter type payload_t = logic
) (
    // top-level flush, seen by both ends in the same cycle
    input logic flush
);

    logic     valid;
    logic     allowin;
    payload_t payload;

    modport producer (
        output valid,
        output payload,
        input  allowin,
        input  flush
    );

    modport consumer (
        input  valid,
        input  payload,
        input  flush,
        output allowin
    );

    // passive view for checkers
    modport monitor (
        input valid,
        input allowin,
        input payload,
        input flush
    );

endinterface

/* src/stage_buffer.sv */
`timescale 1ns/10ps

// one-entry pipeline register
// takes a new entry when empty or when the current one leaves
module stage_buffer #(
    parameter type payload_t = logic
) (
    input logic        clk,
    input logic        resetn,
    stage_if.consumer  in,
    stage_if.producer  out
);

    logic     valid_q;
    payload_t data_q;

    // empty, or downstream takes the current entry this cycle
    assign in.allowin = ~valid_q | out.allowin;

    // nothing moves on in a flush cycle
    assign out.valid   = valid_q & ~in.flush;
    assign out.payload = data_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (in.flush) begin
            valid_q <= 1'b0;
        end else if (in.allowin) begin
            valid_q <= in.valid;
        end
    end

    // payload only, written on a transfer
    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            data_q <= in.payload;
        end
    end

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/10ps

// pre-IF request generation and IF return handling
// at most one request in flight on the instruction bus
module fetch_stage import fetch_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        flush,
    input  logic [31:0] flush_target,
    input  redirect_t   redirect,
    stage_if.producer   fd,
    output logic        inst_sram_req,
    output logic [31:0] inst_sram_addr,
    input  logic        inst_sram_addr_ok,
    input  logic        inst_sram_data_ok,
    input  logic [31:0] inst_sram_rdata
);

    // pc of the last accepted request
    logic [31:0] if_pc;
    logic        inflight;
    // return of the in-flight request is stale
    logic        cancel_q;

    // holding register for returns that decode cannot take yet
    logic        hold_valid;
    logic [31:0] hold_inst;

    // redirects waiting for the bus to take the address
    logic        flush_q;
    logic [31:0] flush_tgt_q;
    logic        br_q;
    logic [31:0] br_tgt_q;

    logic [31:0] seq_pc;
    logic [31:0] pre_pc;
    logic        fire_req;
    logic        kill;
    logic        out_valid;
    logic        can_req;
    logic [31:0] cur_inst;

    // flush or taken branch makes everything behind it stale
    assign kill = flush | redirect.taken;

    // instruction ready from the holding reg or straight off the bus
    assign out_valid = ~kill & (hold_valid | (inst_sram_data_ok & ~cancel_q));
    assign cur_inst  = hold_valid ? hold_inst : inst_sram_rdata;

    assign fd.valid   = out_valid;
    assign fd.payload = '{pc: if_pc, inst: cur_inst, adef: |if_pc[1:0]};

    // new request only if the slot is free after this cycle
    // i.e. no pending return and nothing left stuck for decode
    assign can_req = (~inflight | inst_sram_data_ok) & ~(out_valid & ~fd.allowin);

    // req held low in reset, rises on the first cycle out of it
    assign inst_sram_req  = resetn & can_req;
    assign inst_sram_addr = pre_pc;
    assign fire_req       = inst_sram_req & inst_sram_addr_ok;

    // next pc, a live flush wins over any remembered target
    assign seq_pc = if_pc + 32'd4;
    assign pre_pc = flush          ? flush_target    :
                    flush_q        ? flush_tgt_q     :
                    br_q           ? br_tgt_q        :
                    redirect.taken ? redirect.target :
                    seq_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_pc <= reset_pc - 32'd4;
        end else if (fire_req) begin
            if_pc <= pre_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inflight <= 1'b0;
        end else if (fire_req) begin
            inflight <= 1'b1;
        end else if (inst_sram_data_ok) begin
            inflight <= 1'b0;
        end
    end

    // stale return still on its way, drop it when it shows up
    // a return in the kill cycle itself is dropped by out_valid
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_q <= 1'b0;
        end else if (kill && inflight && !inst_sram_data_ok) begin
            cancel_q <= 1'b1;
        end else if (inst_sram_data_ok) begin
            cancel_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            hold_valid <= 1'b0;
        end else if (kill) begin
            hold_valid <= 1'b0;
        end else if (out_valid && fd.allowin) begin
            hold_valid <= 1'b0;
        end else if (inst_sram_data_ok && !cancel_q) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_sram_data_ok && !cancel_q && !hold_valid) begin
            hold_inst <= inst_sram_rdata;
        end
    end

    // flush seen while the bus refuses the target
    always_ff @(posedge clk) begin
        if (!resetn) begin
            flush_q <= 1'b0;
        end else if (fire_req) begin
            flush_q <= 1'b0;
        end else if (flush) begin
            flush_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (flush && !fire_req) begin
            flush_tgt_q <= flush_target;
        end
    end

    // taken branch not yet on the bus
    always_ff @(posedge clk) begin
        if (!resetn) begin
            br_q <= 1'b0;
        end else if (fire_req) begin
            br_q <= 1'b0;
        end else if (redirect.taken) begin
            br_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.taken && !fire_req) begin
            br_tgt_q <= redirect.target;
        end
    end

endmodule

/* src/branch_decode.sv */
`timescale 1ns/10ps

// decode stage, resolves B and BL and redirects fetch
module branch_decode import fetch_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    stage_if.consumer  fd,
    stage_if.producer  dr,
    output redirect_t  redirect
);

    // buffered instruction, read side of the stage register
    stage_if #(.payload_t(fetch_payload_t)) dq (.flush(fd.flush));

    fetch_payload_t  cur;
    decode_payload_t dec;
    logic            fresh_q;
    logic            is_branch;
    logic [31:0]     offs;

    stage_buffer #(
        .payload_t(fetch_payload_t)
    ) buf0 (
        .clk    (clk),
        .resetn (resetn),
        .in     (fd),
        .out    (dq)
    );

    // entry arrived last cycle, redirect fires only then
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fresh_q <= 1'b0;
        end else begin
            fresh_q <= fd.valid & fd.allowin & ~fd.flush;
        end
    end

    assign cur = dq.payload;

    // misaligned fetch is never a branch
    assign is_branch = ~cur.adef &
                       ((cur.inst[31:26] == op_b) | (cur.inst[31:26] == op_bl));

    // offs26: high 10 bits in inst[9:0], low 16 in inst[25:10]
    assign offs = {{4{cur.inst[9]}}, cur.inst[9:0], cur.inst[25:10], 2'b00};

    always_comb begin
        redirect.taken  = dq.valid & fresh_q & is_branch;
        redirect.target = cur.pc + offs;
    end

    always_comb begin
        dec.pc        = cur.pc;
        dec.inst      = cur.inst;
        dec.adef      = cur.adef;
        dec.is_branch = is_branch;
    end

    // stage register drains when retire takes the entry
    assign dr.valid   = dq.valid;
    assign dr.payload = dec;
    assign dq.allowin = dr.allowin;

endmodule

/* src/retire_stage.sv */
`timescale 1ns/10ps

// last stage, hands committed instructions to the consumer
module retire_stage import fetch_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    stage_if.consumer   dr,
    input  logic        retire_ready,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_inst,
    output logic        retire_adef
);

    // output side of the retire register
    stage_if #(.payload_t(decode_payload_t)) rq (.flush(dr.flush));

    decode_payload_t cur;

    stage_buffer #(
        .payload_t(decode_payload_t)
    ) buf0 (
        .clk    (clk),
        .resetn (resetn),
        .in     (dr),
        .out    (rq)
    );

    // consumer back-pressure holds the entry
    // and, through allowin, everything behind it
    assign rq.allowin = retire_ready;

    assign cur = rq.payload;

    assign retire_valid = rq.valid;
    assign retire_pc    = cur.pc;
    assign retire_inst  = cur.inst;
    assign retire_adef  = cur.adef;

endmodule

/* src/fetch_top.sv */
`timescale 1ns/10ps

// instruction-fetch front end
// fetch -> branch decode -> retire
module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    // instruction bus, read only, 4 bytes
    output logic        inst_sram_req,
    output logic [31:0] inst_sram_addr,
    input  logic        inst_sram_addr_ok,
    input  logic        inst_sram_data_ok,
    input  logic [31:0] inst_sram_rdata,

    // pipeline flush with new fetch address
    input  logic        flush,
    input  logic [31:0] flush_target,

    // committed instruction stream
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_inst,
    output logic        retire_adef,
    input  logic        retire_ready
);

    redirect_t br_redirect;

    stage_if #(.payload_t(fetch_payload_t))  fd (.flush(flush));
    stage_if #(.payload_t(decode_payload_t)) dr (.flush(flush));

    fetch_stage fetch0 (
        .clk               (clk),
        .resetn            (resetn),
        .flush             (flush),
        .flush_target      (flush_target),
        .redirect          (br_redirect),
        .fd                (fd),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata)
    );

    branch_decode decode0 (
        .clk      (clk),
        .resetn   (resetn),
        .fd       (fd),
        .dr       (dr),
        .redirect (br_redirect)
    );

    retire_stage retire0 (
        .clk          (clk),
        .resetn       (resetn),
        .dr           (dr),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_adef  (retire_adef)
    );

endmodule

/* sim/tb_imem.sv */
`timescale 1ns/10ps

// instruction memory on the req/addr_ok/data_ok bus
// random addr_ok, in-order returns after a random delay
module tb_imem import fetch_pkg::*; #(
    parameter int prog_len = 256
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    // program image starting at reset_pc, loaded by the testbench
    logic [31:0] prog [prog_len];

    // accepted addresses and the cycle each one may return in
    logic [31:0] addr_q [$];
    int          due_q [$];
    int          cyc;

    // words outside the program, opcode 000111 is never B or BL
    function automatic logic [31:0] filler_word(input logic [31:0] a);
        logic [31:0] h;
        h = (a ^ {a[15:0], a[31:16]}) * 32'h9e37_79b1;
        return {6'b000111, h[25:0]};
    endfunction

    // misaligned addresses read the word they fall in
    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [31:0] idx;
        idx = (a - reset_pc) >> 2;
        if (a >= reset_pc && idx < prog_len) begin
            return prog[idx];
        end
        return filler_word({a[31:2], 2'b00});
    endfunction

    initial begin
        cyc     = 0;
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = 32'd0;
    end

    always @(posedge clk) begin
        cyc++;
        // handshake as seen at this edge
        if (resetn && req && addr_ok) begin
            addr_q.push_back(addr);
            due_q.push_back(cyc + int'($urandom % 4));
        end
        #1;
        data_ok = 1'b0;
        // earliest return is the cycle after acceptance
        if (due_q.size() > 0 && due_q[0] <= cyc) begin
            data_ok = 1'b1;
            rdata   = word_at(addr_q.pop_front());
            void'(due_q.pop_front());
        end
        addr_ok = ($urandom % 4) != 0;
    end

endmodule

/* sim/tb_fetch_top.sv */
`timescale 1ns/10ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int seed        = 47;
    localparam int prog_len    = 256;
    localparam int num_retires = 3000;
    // retire_ready high this many percent of cycles
    localparam int ready_pct   = 75;
    // one flush in this many cycles, one misaligned target in adef_div
    localparam int flush_div   = 40;
    localparam int adef_div    = 6;

    logic        clk = 1'b0;
    logic        resetn;
    logic        req;
    logic [31:0] addr;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        flush;
    logic [31:0] flush_target;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_inst;
    logic        retire_adef;
    logic        retire_ready;

    // reference walk state
    logic [31:0] exp_pc = reset_pc;
    logic        run_q = 1'b0;
    int          retired = 0;
    int          n_branch = 0;
    int          n_adef = 0;
    int          n_flush = 0;
    // flushes whose target the bus did not take in the same cycle
    int          n_flush_late = 0;

    always #5 clk = ~clk;

    fetch_top dut0 (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (req),
        .inst_sram_addr    (addr),
        .inst_sram_addr_ok (addr_ok),
        .inst_sram_data_ok (data_ok),
        .inst_sram_rdata   (rdata),
        .flush             (flush),
        .flush_target      (flush_target),
        .retire_valid      (retire_valid),
        .retire_pc         (retire_pc),
        .retire_inst       (retire_inst),
        .retire_adef       (retire_adef),
        .retire_ready      (retire_ready)
    );

    tb_imem #(.prog_len(prog_len)) imem0 (
        .clk     (clk),
        .resetn  (resetn),
        .req     (req),
        .addr    (addr),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // expected successor of pc, branches only when aligned
    function automatic logic [31:0] ref_next_pc(input logic [31:0] pc);
        logic [31:0] inst;
        logic [25:0] offs26;
        inst   = imem0.word_at(pc);
        offs26 = {inst[9:0], inst[25:10]};
        if (pc[1:0] == 2'b00 && (inst[31:26] == op_b || inst[31:26] == op_bl)) begin
            return pc + {{4{offs26[25]}}, offs26, 2'b00};
        end
        return pc + 32'd4;
    endfunction

    // one in five words a branch, mostly forward
    function automatic logic [31:0] random_program_word();
        logic [31:0] w;
        int          k;
        w = $urandom;
        if (($urandom % 5) == 0) begin
            if (($urandom % 4) == 0) begin
                k = -(1 + int'($urandom % 6));
            end else begin
                k = 1 + int'($urandom % 12);
            end
            w = {(w[0] ? op_bl : op_b), k[15:0], k[25:16]};
        end else if (w[31:27] == 5'b01010) begin
            // keep fillers off the B/BL opcodes
            w[30] = 1'b0;
        end
        return w;
    endfunction

    // no flush before the first retire, so the reset path is seen
    task automatic drive_random_inputs();
        logic [31:0] tgt;
        retire_ready = ($urandom % 100) < ready_pct;
        flush        = (($urandom % flush_div) == 0) && (retired > 0);
        tgt          = reset_pc + 4 * ($urandom % prog_len);
        if (($urandom % adef_div) == 0) begin
            tgt[1:0] = 2'(($urandom % 3) + 1);
        end
        flush_target = tgt;
    endtask

    initial begin
        void'($urandom(seed));
        for (int i = 0; i < prog_len; i++) begin
            imem0.prog[i] = random_program_word();
        end
        resetn       = 1'b0;
        flush        = 1'b0;
        flush_target = 32'd0;
        retire_ready = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        while (retired < num_retires) begin
            @(posedge clk);
            #1;
            drive_random_inputs();
        end
        $display("retired %0d, branches %0d, misaligned %0d, flushes %0d (%0d delayed)",
                 retired, n_branch, n_adef, n_flush, n_flush_late);
        if (n_branch == 0 || n_adef == 0 || n_flush_late == 0) begin
            $display("Error: run saw no taken branch, no misaligned fetch or no delayed flush");
            $display("*** TEST FAILED ***");
            $fatal(1);
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    // compare at negedge, values there hold through the next edge
    always @(negedge clk) begin
        if (!resetn) begin
            check_value("inst_sram_req", req, 1'b0);
            check_value("retire_valid", retire_valid, 1'b0);
        end else if (!run_q) begin
            // first cycle out of reset asks for reset_pc
            check_value("inst_sram_req", req, 1'b1);
            check_value("inst_sram_addr", addr, reset_pc);
            run_q = 1'b1;
        end
        if (resetn && flush) begin
            // no retire in a flush cycle, walk restarts at the target
            exp_pc = flush_target;
            n_flush++;
            // outstanding return or refused address
            if (!(req && addr_ok)) begin
                n_flush_late++;
            end
        end else if (resetn && retire_valid && retire_ready) begin
            check_value("retire_pc", retire_pc, exp_pc);
            check_value("retire_inst", retire_inst, imem0.word_at(exp_pc));
            check_value("retire_adef", retire_adef, |exp_pc[1:0]);
            if (exp_pc[1:0] != 2'b00) begin
                n_adef++;
            end else if (ref_next_pc(exp_pc) != exp_pc + 32'd4) begin
                n_branch++;
            end
            exp_pc = ref_next_pc(exp_pc);
            retired++;
        end
    end

    // budget of 200 cycles per retired instruction
    initial begin
        repeat (num_retires * 200) @(posedge clk);
        $display("Timeout: retirement stalled after %0d of %0d instructions",
                 retired, num_retires);
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

endmodule

/* list.f */
src/fetch_pkg.sv
src/stage_if.sv
src/stage_buffer.sv
src/fetch_stage.sv
src/branch_decode.sv
src/retire_stage.sv
src/fetch_top.sv
sim/tb_imem.sv
sim/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  - files:
      - src/fetch_pkg.sv
      - src/stage_if.sv
      - src/stage_buffer.sv
      - src/fetch_stage.sv
      - src/branch_decode.sv
      - src/retire_stage.sv
      - src/fetch_top.sv
  - target: test
    files:
      - sim/tb_imem.sv
      - sim/tb_fetch_top.sv
